// File: dv/golden_axi_txn.txt
// op id addr wdata strb resp rdata, all hex; resp 0 OKAY, 2 SLVERR
// op 0 read, 1 write then wait for b, 2 write without waiting
0 1 00000000 00000000 0 0 00000000
0 2 00000010 00000000 0 0 00000000
0 3 000000FC 00000000 0 0 00000000
1 3 00000004 DEADBEEF F 0 00000000
0 5 00000004 00000000 0 0 DEADBEEF
1 7 00000008 11223344 F 0 00000000
1 8 00000008 AABBCCDD 5 0 00000000
0 9 00000008 00000000 0 0 11BB33DD
1 A 0000000C CAFEF00D A 0 00000000
0 B 0000000C 00000000 0 0 CA00F000
1 C 00000004 00000055 1 0 00000000
0 D 00000004 00000000 0 0 DEADBE55
1 E 00000100 12345678 F 2 00000000
0 F 00000100 00000000 0 2 00000000
1 0 00001000 87654321 F 2 00000000
0 1 FFFFFFFC 00000000 0 2 00000000
0 2 00000000 00000000 0 0 00000000
1 4 000000FC A5A5A5A5 F 0 00000000
0 6 000000FC 00000000 0 0 A5A5A5A5
2 1 00000040 10000001 F 0 00000000
2 2 00000044 20000002 F 0 00000000
2 3 00000048 30000003 F 0 00000000
2 4 0000004C 40000004 F 0 00000000
2 5 00000050 50000005 F 0 00000000
2 6 00000054 60000006 F 0 00000000
2 7 00000058 70000007 F 0 00000000
2 8 0000005C 80000008 3 0 00000000
0 9 00000040 00000000 0 0 10000001
0 A 00000044 00000000 0 0 20000002
0 B 00000048 00000000 0 0 30000003
0 C 0000004C 00000000 0 0 40000004
0 D 00000050 00000000 0 0 50000005
0 E 00000054 00000000 0 0 60000006
0 F 00000058 00000000 0 0 70000007
0 0 0000005C 00000000 0 0 00000008

// File: sources.f
rtl/axi_pkg.sv
rtl/mem_pkg.sv
rtl/fifo_buf.sv
rtl/axi_fifo.sv
rtl/axi_mem_sub.sv
rtl/axi_buf_mem_top.sv
dv/tb_axi_buf_mem.sv

// File: Makefile
# Verilator build and run of the buffered AXI memory testbench

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  help   list the targets"
	@echo "  test   build the testbench with Verilator and run it"
	@echo "  clean  remove the Verilator build directory"

test:
	verilator --binary --timing --assert --top-module tb_axi_buf_mem -f sources.f
	@out=$$(./obj_dir/Vtb_axi_buf_mem); \
	echo "$$out"; \
	echo "$$out" | grep -q "^Simulation completed successfully$$"

clean:
	rm -rf obj_dir

// File: dv/tb_axi_buf_mem.sv
/*
 * Testbench for the buffered AXI4 memory, driven from the golden transaction file,
 * with random back-pressure on the response channels
 */
`timescale 1ns/100ps

module tb_axi_buf_mem;

  import axi_pkg::*;

  localparam int HalfPeriod  = 50;
  localparam int DriveDelay  = 10;
  localparam int ResetCycles = 10;
  localparam int MaxTxn      = 64;
  localparam int TxnFields   = 7;
  localparam int GoldenWords = MaxTxn * TxnFields;

  logic     clk_i;
  logic     rst_n_i;
  aw_chan_t sbr_aw_i;
  logic     sbr_aw_valid_i;
  logic     sbr_aw_ready_o;
  w_chan_t  sbr_w_i;
  logic     sbr_w_valid_i;
  logic     sbr_w_ready_o;
  ar_chan_t sbr_ar_i;
  logic     sbr_ar_valid_i;
  logic     sbr_ar_ready_o;
  b_chan_t  sbr_b_o;
  logic     sbr_b_valid_o;
  logic     sbr_b_ready_i;
  r_chan_t  sbr_r_o;
  logic     sbr_r_valid_o;
  logic     sbr_r_ready_i;

  logic [31:0] golden_mem [0:GoldenWords-1];
  b_chan_t     exp_b_q [$];
  r_chan_t     exp_r_q [$];
  int          b_txn_q [$];
  int          r_txn_q [$];
  int          mismatch_count;
  int          response_errors;
  int          run_errors;
  int          timeout_cycles;
  int          cycle_count;
  integer      seed;
  bit          saw_aw_stall;

  axi_buf_mem_top #(
    .Depth      (2),
    .FallThrough(1'b0)
  ) i_axi_buf_mem_top (.*);

  initial begin
    clk_i = 1'b0;
    forever #HalfPeriod clk_i = ~clk_i;
  end

  task automatic check_resp(input string name, input resp_t exp, input resp_t act);
    if (exp !== act) begin
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
      mismatch_count++;
    end
  endtask

  task automatic check_data(input string name, input data_t exp, input data_t act);
    if (exp !== act) begin
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
      mismatch_count++;
    end
  endtask

  task automatic check_id(input string name, input id_t exp, input id_t act);
    if (exp !== act) begin
      $display("CHECK FAILED %s: expected %h, actual %h", name, exp, act);
      mismatch_count++;
    end
  endtask

  // Ready inputs high on about three cycles in four
  initial begin
    sbr_b_ready_i = 1'b0;
    sbr_r_ready_i = 1'b0;
    seed = 32'h6f9563f7;
    wait (rst_n_i === 1'b1);
    forever begin
      @(posedge clk_i);
      #DriveDelay;
      sbr_b_ready_i = (($random(seed) & 32'd3) != 0);
      sbr_r_ready_i = (($random(seed) & 32'd3) != 0);
    end
  end

  // Response monitor samples mid-cycle before each transfer edge
  initial begin
    b_chan_t exp_b;
    r_chan_t exp_r;
    int      t;
    forever begin
      @(negedge clk_i);
      if (rst_n_i && sbr_b_valid_o && sbr_b_ready_i) begin
        if (exp_b_q.size() == 0) begin
          $display("Write response with id %h arrived with no write outstanding", sbr_b_o.id);
          response_errors++;
        end else begin
          exp_b = exp_b_q.pop_front();
          t = b_txn_q.pop_front();
          check_id($sformatf("txn %0d write id", t), exp_b.id, sbr_b_o.id);
          check_resp($sformatf("txn %0d write resp", t), exp_b.resp, sbr_b_o.resp);
        end
      end
      if (rst_n_i && sbr_r_valid_o && sbr_r_ready_i) begin
        if (exp_r_q.size() == 0) begin
          $display("Read response with id %h arrived with no read outstanding", sbr_r_o.id);
          response_errors++;
        end else begin
          exp_r = exp_r_q.pop_front();
          t = r_txn_q.pop_front();
          check_id($sformatf("txn %0d read id", t), exp_r.id, sbr_r_o.id);
          check_resp($sformatf("txn %0d read resp", t), exp_r.resp, sbr_r_o.resp);
          check_data($sformatf("txn %0d read data", t), exp_r.data, sbr_r_o.data);
          if (sbr_r_o.last !== exp_r.last) begin
            $display("CHECK FAILED txn %0d read last: expected %b, actual %b",
                     t, exp_r.last, sbr_r_o.last);
            mismatch_count++;
          end
        end
      end
    end
  end

  // Run limit scales with the number of transactions
  initial begin
    cycle_count = 0;
    wait (timeout_cycles > 0);
    while (cycle_count < timeout_cycles) begin
      @(posedge clk_i);
      cycle_count++;
    end
    $display("Timeout: the run did not finish within %0d cycles", timeout_cycles);
    $display("Simulation failed");
    $finish;
  end

  task automatic wait_writes_done();
    while (exp_b_q.size() != 0) begin
      @(posedge clk_i);
      #DriveDelay;
    end
  endtask

  task automatic wait_reads_done();
    while (exp_r_q.size() != 0) begin
      @(posedge clk_i);
      #DriveDelay;
    end
  endtask

  // aw and w go out together and each valid drops once taken
  task automatic issue_write(input int txn, input id_t id, input addr_t addr,
                             input data_t data, input strb_t strb, input resp_t exp_resp);
    b_chan_t exp_b;
    bit      aw_pend;
    bit      w_pend;
    bit      aw_acc;
    bit      w_acc;
    exp_b.id   = id;
    exp_b.resp = exp_resp;
    exp_b_q.push_back(exp_b);
    b_txn_q.push_back(txn);
    sbr_aw_i.id    = id;
    sbr_aw_i.addr  = addr;
    sbr_aw_i.len   = 8'd0;
    sbr_aw_i.size  = 3'd2;
    sbr_aw_i.burst = 2'b01;
    sbr_w_i.data   = data;
    sbr_w_i.strb   = strb;
    sbr_w_i.last   = 1'b1;
    sbr_aw_valid_i = 1'b1;
    sbr_w_valid_i  = 1'b1;
    aw_pend = 1'b1;
    w_pend  = 1'b1;
    while (aw_pend || w_pend) begin
      @(negedge clk_i);
      aw_acc = sbr_aw_valid_i && sbr_aw_ready_o;
      w_acc  = sbr_w_valid_i && sbr_w_ready_o;
      if (sbr_aw_valid_i && !sbr_aw_ready_o) begin
        saw_aw_stall = 1'b1;
      end
      @(posedge clk_i);
      #DriveDelay;
      if (aw_acc) begin
        aw_pend = 1'b0;
        sbr_aw_valid_i = 1'b0;
      end
      if (w_acc) begin
        w_pend = 1'b0;
        sbr_w_valid_i = 1'b0;
      end
    end
  endtask

  task automatic issue_read(input int txn, input id_t id, input addr_t addr,
                            input resp_t exp_resp, input data_t exp_data);
    r_chan_t exp_r;
    bit      ar_acc;
    exp_r.id   = id;
    exp_r.data = exp_data;
    exp_r.resp = exp_resp;
    exp_r.last = 1'b1;
    exp_r_q.push_back(exp_r);
    r_txn_q.push_back(txn);
    sbr_ar_i.id    = id;
    sbr_ar_i.addr  = addr;
    sbr_ar_i.len   = 8'd0;
    sbr_ar_i.size  = 3'd2;
    sbr_ar_i.burst = 2'b01;
    sbr_ar_valid_i = 1'b1;
    ar_acc = 1'b0;
    while (!ar_acc) begin
      @(negedge clk_i);
      ar_acc = sbr_ar_valid_i && sbr_ar_ready_o;
      @(posedge clk_i);
      #DriveDelay;
    end
    sbr_ar_valid_i = 1'b0;
  endtask

  initial begin
    int num_txn;
    int base;
    int op;
    rst_n_i        = 1'b0;
    sbr_aw_i       = '0;
    sbr_aw_valid_i = 1'b0;
    sbr_w_i        = '0;
    sbr_w_valid_i  = 1'b0;
    sbr_ar_i       = '0;
    sbr_ar_valid_i = 1'b0;
    mismatch_count = 0;
    run_errors     = 0;
    saw_aw_stall   = 1'b0;
    // Unloaded slots keep their inverted index, never a valid op code
    for (int i = 0; i < GoldenWords; i++) begin
      golden_mem[i] = ~32'(i);
    end
    $readmemh("dv/golden_axi_txn.txt", golden_mem);
    num_txn = 0;
    while (num_txn < MaxTxn &&
           golden_mem[TxnFields*num_txn] != ~32'(TxnFields*num_txn)) begin
      num_txn++;
    end
    timeout_cycles = num_txn * 40 + 100;
    if (num_txn == 0) begin
      $display("No transactions were found in the golden file");
      run_errors++;
    end

    repeat (ResetCycles) @(posedge clk_i);
    #DriveDelay;
    rst_n_i = 1'b1;
    @(posedge clk_i);
    #DriveDelay;

    for (int t = 0; t < num_txn; t++) begin
      base = TxnFields * t;
      op   = golden_mem[base];
      case (op)
        // Reads wait until every earlier write has its response
        0: begin
          wait_writes_done();
          issue_read(t, id_t'(golden_mem[base+1]), golden_mem[base+2],
                     resp_t'(golden_mem[base+5]), golden_mem[base+6]);
          wait_reads_done();
        end
        1: begin
          issue_write(t, id_t'(golden_mem[base+1]), golden_mem[base+2], golden_mem[base+3],
                      strb_t'(golden_mem[base+4]), resp_t'(golden_mem[base+5]));
          wait_writes_done();
        end
        2: begin
          issue_write(t, id_t'(golden_mem[base+1]), golden_mem[base+2], golden_mem[base+3],
                      strb_t'(golden_mem[base+4]), resp_t'(golden_mem[base+5]));
        end
        default: begin
          $display("Unknown operation code %0d in golden transaction %0d", op, t);
          run_errors++;
        end
      endcase
    end
    wait_writes_done();
    wait_reads_done();
    repeat (4) @(posedge clk_i);

    if (!saw_aw_stall) begin
      $display("aw_ready never dropped while writes were issued back to back");
      run_errors++;
    end
    $display("Errors: %0d value mismatches, %0d response errors, %0d run errors",
             mismatch_count, response_errors, run_errors);
    if (mismatch_count == 0 && response_errors == 0 && run_errors == 0) begin
      $display("Simulation completed successfully");
    end else begin
      $display("Simulation failed");
    end
    $finish;
  end

  initial begin
    response_errors = 0;
  end

endmodule

// File: rtl/axi_buf_mem_top.sv
/*
 * AXI4 channel buffer in front of the on-chip memory subordinate
 */
`timescale 1ns/100ps

module axi_buf_mem_top #(
  parameter int unsigned Depth       = 2,
  parameter bit          FallThrough = 1'b0
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  axi_pkg::aw_chan_t sbr_aw_i,
  input  logic              sbr_aw_valid_i,
  output logic              sbr_aw_ready_o,
  input  axi_pkg::w_chan_t  sbr_w_i,
  input  logic              sbr_w_valid_i,
  output logic              sbr_w_ready_o,
  input  axi_pkg::ar_chan_t sbr_ar_i,
  input  logic              sbr_ar_valid_i,
  output logic              sbr_ar_ready_o,
  output axi_pkg::b_chan_t  sbr_b_o,
  output logic              sbr_b_valid_o,
  input  logic              sbr_b_ready_i,
  output axi_pkg::r_chan_t  sbr_r_o,
  output logic              sbr_r_valid_o,
  input  logic              sbr_r_ready_i
);

  import axi_pkg::*;

  // Buffer to memory links
  aw_chan_t mem_aw;
  logic     mem_aw_valid, mem_aw_ready;
  w_chan_t  mem_w;
  logic     mem_w_valid, mem_w_ready;
  ar_chan_t mem_ar;
  logic     mem_ar_valid, mem_ar_ready;
  b_chan_t  mem_b;
  logic     mem_b_valid, mem_b_ready;
  r_chan_t  mem_r;
  logic     mem_r_valid, mem_r_ready;

  axi_fifo #(
    .Depth      (Depth),
    .FallThrough(FallThrough)
  ) i_axi_fifo (
    .clk_i,
    .rst_n_i,
    .sbr_aw_i,
    .sbr_aw_valid_i,
    .sbr_aw_ready_o,
    .sbr_w_i,
    .sbr_w_valid_i,
    .sbr_w_ready_o,
    .sbr_ar_i,
    .sbr_ar_valid_i,
    .sbr_ar_ready_o,
    .sbr_b_o,
    .sbr_b_valid_o,
    .sbr_b_ready_i,
    .sbr_r_o,
    .sbr_r_valid_o,
    .sbr_r_ready_i,
    .mgr_aw_o      (mem_aw),
    .mgr_aw_valid_o(mem_aw_valid),
    .mgr_aw_ready_i(mem_aw_ready),
    .mgr_w_o       (mem_w),
    .mgr_w_valid_o (mem_w_valid),
    .mgr_w_ready_i (mem_w_ready),
    .mgr_ar_o      (mem_ar),
    .mgr_ar_valid_o(mem_ar_valid),
    .mgr_ar_ready_i(mem_ar_ready),
    .mgr_b_i       (mem_b),
    .mgr_b_valid_i (mem_b_valid),
    .mgr_b_ready_o (mem_b_ready),
    .mgr_r_i       (mem_r),
    .mgr_r_valid_i (mem_r_valid),
    .mgr_r_ready_o (mem_r_ready)
  );

  axi_mem_sub i_axi_mem_sub (
    .clk_i,
    .rst_n_i,
    .sbr_aw_i      (mem_aw),
    .sbr_aw_valid_i(mem_aw_valid),
    .sbr_aw_ready_o(mem_aw_ready),
    .sbr_w_i       (mem_w),
    .sbr_w_valid_i (mem_w_valid),
    .sbr_w_ready_o (mem_w_ready),
    .sbr_ar_i      (mem_ar),
    .sbr_ar_valid_i(mem_ar_valid),
    .sbr_ar_ready_o(mem_ar_ready),
    .sbr_b_o       (mem_b),
    .sbr_b_valid_o (mem_b_valid),
    .sbr_b_ready_i (mem_b_ready),
    .sbr_r_o       (mem_r),
    .sbr_r_valid_o (mem_r_valid),
    .sbr_r_ready_i (mem_r_ready)
  );

endmodule

// File: rtl/axi_mem_sub.sv
/*
 * Single-beat AXI4 memory subordinate with byte strobes,
 * range checking and one outstanding read and write
 */
`timescale 1ns/100ps

module axi_mem_sub (
  input  logic              clk_i,
  input  logic              rst_n_i,
  input  axi_pkg::aw_chan_t sbr_aw_i,
  input  logic              sbr_aw_valid_i,
  output logic              sbr_aw_ready_o,
  input  axi_pkg::w_chan_t  sbr_w_i,
  input  logic              sbr_w_valid_i,
  output logic              sbr_w_ready_o,
  input  axi_pkg::ar_chan_t sbr_ar_i,
  input  logic              sbr_ar_valid_i,
  output logic              sbr_ar_ready_o,
  output axi_pkg::b_chan_t  sbr_b_o,
  output logic              sbr_b_valid_o,
  input  logic              sbr_b_ready_i,
  output axi_pkg::r_chan_t  sbr_r_o,
  output logic              sbr_r_valid_o,
  input  logic              sbr_r_ready_i
);

  import axi_pkg::*;
  import mem_pkg::*;

  data_t    mem_q [MemWords];
  aw_chan_t aw_q;
  w_chan_t  w_q;
  logic     aw_held_q;
  logic     w_held_q;
  b_chan_t  b_q;
  logic     b_valid_q;
  r_chan_t  r_q;
  logic     r_valid_q;
  mem_idx_t wr_idx;
  mem_idx_t rd_idx;
  logic     wr_in_range;
  logic     rd_in_range;
  logic     aw_hs;
  logic     w_hs;
  logic     ar_hs;
  logic     do_write;

  // Address decode, low bits select the byte lane only
  assign wr_idx      = aw_q.addr[WordOffset +: IdxWidth];
  assign rd_idx      = sbr_ar_i.addr[WordOffset +: IdxWidth];
  assign wr_in_range = (aw_q.addr < MemBytes);
  assign rd_in_range = (sbr_ar_i.addr < MemBytes);

  // Each write channel takes one beat, then waits for the response to drain
  assign sbr_aw_ready_o = !aw_held_q && !b_valid_q;
  assign sbr_w_ready_o  = !w_held_q && !b_valid_q;
  assign sbr_ar_ready_o = !r_valid_q;

  assign aw_hs    = sbr_aw_valid_i && sbr_aw_ready_o;
  assign w_hs     = sbr_w_valid_i && sbr_w_ready_o;
  assign ar_hs    = sbr_ar_valid_i && sbr_ar_ready_o;
  assign do_write = aw_held_q && w_held_q;

  assign sbr_b_o       = b_q;
  assign sbr_b_valid_o = b_valid_q;
  assign sbr_r_o       = r_q;
  assign sbr_r_valid_o = r_valid_q;

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      aw_held_q <= 1'b0;
      w_held_q  <= 1'b0;
      b_valid_q <= 1'b0;
      r_valid_q <= 1'b0;
    end else begin
      if (aw_hs) begin
        aw_held_q <= 1'b1;
      end else if (do_write) begin
        aw_held_q <= 1'b0;
      end
      if (w_hs) begin
        w_held_q <= 1'b1;
      end else if (do_write) begin
        w_held_q <= 1'b0;
      end
      if (do_write) begin
        b_valid_q <= 1'b1;
      end else if (sbr_b_ready_i) begin
        b_valid_q <= 1'b0;
      end
      if (ar_hs) begin
        r_valid_q <= 1'b1;
      end else if (sbr_r_ready_i) begin
        r_valid_q <= 1'b0;
      end
    end
  end

  // Captured requests and pending responses
  always_ff @(posedge clk_i) begin
    if (aw_hs) begin
      aw_q <= sbr_aw_i;
    end
    if (w_hs) begin
      w_q <= sbr_w_i;
    end
    if (do_write) begin
      b_q.id   <= aw_q.id;
      b_q.resp <= wr_in_range ? RespOkay : RespSlvErr;
    end
    if (ar_hs) begin
      r_q.id   <= sbr_ar_i.id;
      r_q.data <= rd_in_range ? mem_q[rd_idx] : '0;
      r_q.resp <= rd_in_range ? RespOkay : RespSlvErr;
      r_q.last <= 1'b1;
    end
  end

  // Storage, only strobed lanes of an in-range word change
  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      for (int i = 0; i < MemWords; i++) begin
        mem_q[i] <= MemResetValue;
      end
    end else if (do_write && wr_in_range) begin
      for (int b = 0; b < StrbWidth; b++) begin
        if (w_q.strb[b]) begin
          mem_q[wr_idx][8*b +: 8] <= w_q.data[8*b +: 8];
        end
      end
    end
  end

  // Bursts are not supported
  a_aw_single_beat : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    sbr_aw_valid_i |-> sbr_aw_i.len == '0)
    else $error("axi_mem_sub: aw burst with len %0d", sbr_aw_i.len);

  a_ar_single_beat : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    sbr_ar_valid_i |-> sbr_ar_i.len == '0)
    else $error("axi_mem_sub: ar burst with len %0d", sbr_ar_i.len);

endmodule

// File: rtl/axi_fifo.sv
/*
 * AXI4 channel buffer, one queue per channel,
 * or a straight connection when Depth is zero
 */
`timescale 1ns/100ps

module axi_fifo #(
  parameter int unsigned Depth       = 2,
  parameter bit          FallThrough = 1'b0
) (
  input  logic              clk_i,
  input  logic              rst_n_i,
  // Subordinate side, towards the external manager
  input  axi_pkg::aw_chan_t sbr_aw_i,
  input  logic              sbr_aw_valid_i,
  output logic              sbr_aw_ready_o,
  input  axi_pkg::w_chan_t  sbr_w_i,
  input  logic              sbr_w_valid_i,
  output logic              sbr_w_ready_o,
  input  axi_pkg::ar_chan_t sbr_ar_i,
  input  logic              sbr_ar_valid_i,
  output logic              sbr_ar_ready_o,
  output axi_pkg::b_chan_t  sbr_b_o,
  output logic              sbr_b_valid_o,
  input  logic              sbr_b_ready_i,
  output axi_pkg::r_chan_t  sbr_r_o,
  output logic              sbr_r_valid_o,
  input  logic              sbr_r_ready_i,
  // Manager side, towards the memory
  output axi_pkg::aw_chan_t mgr_aw_o,
  output logic              mgr_aw_valid_o,
  input  logic              mgr_aw_ready_i,
  output axi_pkg::w_chan_t  mgr_w_o,
  output logic              mgr_w_valid_o,
  input  logic              mgr_w_ready_i,
  output axi_pkg::ar_chan_t mgr_ar_o,
  output logic              mgr_ar_valid_o,
  input  logic              mgr_ar_ready_i,
  input  axi_pkg::b_chan_t  mgr_b_i,
  input  logic              mgr_b_valid_i,
  output logic              mgr_b_ready_o,
  input  axi_pkg::r_chan_t  mgr_r_i,
  input  logic              mgr_r_valid_i,
  output logic              mgr_r_ready_o
);

  import axi_pkg::*;

  if (Depth == 0) begin : gen_no_fifo
    // Plain wires, no added latency
    assign mgr_aw_o       = sbr_aw_i;
    assign mgr_aw_valid_o = sbr_aw_valid_i;
    assign sbr_aw_ready_o = mgr_aw_ready_i;
    assign mgr_w_o        = sbr_w_i;
    assign mgr_w_valid_o  = sbr_w_valid_i;
    assign sbr_w_ready_o  = mgr_w_ready_i;
    assign mgr_ar_o       = sbr_ar_i;
    assign mgr_ar_valid_o = sbr_ar_valid_i;
    assign sbr_ar_ready_o = mgr_ar_ready_i;
    assign sbr_b_o        = mgr_b_i;
    assign sbr_b_valid_o  = mgr_b_valid_i;
    assign mgr_b_ready_o  = sbr_b_ready_i;
    assign sbr_r_o        = mgr_r_i;
    assign sbr_r_valid_o  = mgr_r_valid_i;
    assign mgr_r_ready_o  = sbr_r_ready_i;
  end else begin : gen_fifo
    logic aw_full, w_full, ar_full, b_full, r_full;
    logic aw_empty, w_empty, ar_empty, b_empty, r_empty;

    // Upstream ready follows free space, downstream valid follows content
    assign sbr_aw_ready_o = !aw_full;
    assign sbr_w_ready_o  = !w_full;
    assign sbr_ar_ready_o = !ar_full;
    assign mgr_b_ready_o  = !b_full;
    assign mgr_r_ready_o  = !r_full;

    assign mgr_aw_valid_o = !aw_empty;
    assign mgr_w_valid_o  = !w_empty;
    assign mgr_ar_valid_o = !ar_empty;
    assign sbr_b_valid_o  = !b_empty;
    assign sbr_r_valid_o  = !r_empty;

    fifo_buf #(.Depth(Depth), .FallThrough(FallThrough), .dtype(aw_chan_t)) i_aw_fifo (
      .clk_i,
      .rst_n_i,
      .data_i (sbr_aw_i),
      .push_i (sbr_aw_valid_i && sbr_aw_ready_o),
      .data_o (mgr_aw_o),
      .pop_i  (mgr_aw_valid_o && mgr_aw_ready_i),
      .full_o (aw_full),
      .empty_o(aw_empty)
    );

    fifo_buf #(.Depth(Depth), .FallThrough(FallThrough), .dtype(w_chan_t)) i_w_fifo (
      .clk_i,
      .rst_n_i,
      .data_i (sbr_w_i),
      .push_i (sbr_w_valid_i && sbr_w_ready_o),
      .data_o (mgr_w_o),
      .pop_i  (mgr_w_valid_o && mgr_w_ready_i),
      .full_o (w_full),
      .empty_o(w_empty)
    );

    fifo_buf #(.Depth(Depth), .FallThrough(FallThrough), .dtype(ar_chan_t)) i_ar_fifo (
      .clk_i,
      .rst_n_i,
      .data_i (sbr_ar_i),
      .push_i (sbr_ar_valid_i && sbr_ar_ready_o),
      .data_o (mgr_ar_o),
      .pop_i  (mgr_ar_valid_o && mgr_ar_ready_i),
      .full_o (ar_full),
      .empty_o(ar_empty)
    );

    // Response queues run from manager side back to subordinate side
    fifo_buf #(.Depth(Depth), .FallThrough(FallThrough), .dtype(b_chan_t)) i_b_fifo (
      .clk_i,
      .rst_n_i,
      .data_i (mgr_b_i),
      .push_i (mgr_b_valid_i && mgr_b_ready_o),
      .data_o (sbr_b_o),
      .pop_i  (sbr_b_valid_o && sbr_b_ready_i),
      .full_o (b_full),
      .empty_o(b_empty)
    );

    fifo_buf #(.Depth(Depth), .FallThrough(FallThrough), .dtype(r_chan_t)) i_r_fifo (
      .clk_i,
      .rst_n_i,
      .data_i (mgr_r_i),
      .push_i (mgr_r_valid_i && mgr_r_ready_o),
      .data_o (sbr_r_o),
      .pop_i  (sbr_r_valid_o && sbr_r_ready_i),
      .full_o (r_full),
      .empty_o(r_empty)
    );
  end

  // Manager must hold a stalled request steady until it is taken
  a_aw_stable : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    sbr_aw_valid_i && !sbr_aw_ready_o |=> sbr_aw_valid_i && $stable(sbr_aw_i))
    else $error("axi_fifo: aw payload changed while stalled");

  a_w_stable : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    sbr_w_valid_i && !sbr_w_ready_o |=> sbr_w_valid_i && $stable(sbr_w_i))
    else $error("axi_fifo: w payload changed while stalled");

endmodule

// File: rtl/fifo_buf.sv
/*
 * Synchronous circular queue for any payload type,
 * with full and empty flags and an optional fall-through path
 */
`timescale 1ns/100ps

module fifo_buf #(
  parameter int unsigned Depth       = 2,
  parameter bit          FallThrough = 1'b0,
  parameter type         dtype       = logic
) (
  input  logic clk_i,
  input  logic rst_n_i,
  input  dtype data_i,
  input  logic push_i,
  output dtype data_o,
  input  logic pop_i,
  output logic full_o,
  output logic empty_o
);

  localparam int unsigned PtrWidth = (Depth > 1) ? $clog2(Depth) : 1;
  localparam int unsigned CntWidth = $clog2(Depth + 1);
  localparam logic [PtrWidth-1:0] LastSlot = PtrWidth'(Depth - 1);

  dtype                mem_q [Depth];
  logic [PtrWidth-1:0] rd_ptr_q;
  logic [PtrWidth-1:0] wr_ptr_q;
  logic [CntWidth-1:0] count_q;
  logic                bypass;
  logic                do_write;
  logic                do_read;

  // Push into an empty queue goes straight to the output in fall-through mode
  assign bypass = FallThrough && (count_q == '0) && push_i;

  // A bypassed item popped in the same cycle never touches the storage
  assign do_write = push_i && !(bypass && pop_i);
  assign do_read  = pop_i && !bypass;

  assign full_o  = (count_q == CntWidth'(Depth));
  assign empty_o = (count_q == '0) && !bypass;
  assign data_o  = bypass ? data_i : mem_q[rd_ptr_q];

  always_ff @(posedge clk_i or negedge rst_n_i) begin
    if (!rst_n_i) begin
      rd_ptr_q <= '0;
      wr_ptr_q <= '0;
      count_q  <= '0;
    end else begin
      if (do_write) begin
        wr_ptr_q <= (wr_ptr_q == LastSlot) ? '0 : wr_ptr_q + 1'b1;
      end
      if (do_read) begin
        rd_ptr_q <= (rd_ptr_q == LastSlot) ? '0 : rd_ptr_q + 1'b1;
      end
      // Occupancy stays put on a simultaneous push and pop
      if (do_write && !do_read) begin
        count_q <= count_q + 1'b1;
      end else if (do_read && !do_write) begin
        count_q <= count_q - 1'b1;
      end
    end
  end

  always_ff @(posedge clk_i) begin
    if (do_write) begin
      mem_q[wr_ptr_q] <= data_i;
    end
  end

  // The parent gates push and pop with the flags
  a_no_push_full : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    push_i |-> !full_o)
    else $error("fifo_buf: push while full");

  a_no_pop_empty : assert property (@(posedge clk_i) disable iff (!rst_n_i)
    pop_i |-> !empty_o)
    else $error("fifo_buf: pop while empty");

endmodule

// File: rtl/mem_pkg.sv
/*
 * Memory geometry, word index type and reset fill value
 */
package mem_pkg;

  // Storage depth in 32-bit words
  localparam int unsigned MemWords = 64;

  // Byte offset bits inside a word, dropped when indexing
  localparam int unsigned WordOffset = 2;

  // First byte address past the end of the memory
  localparam int unsigned MemBytes = MemWords << WordOffset;

  localparam int unsigned IdxWidth = $clog2(MemWords);

  typedef logic [IdxWidth-1:0] mem_idx_t;

  // Content of every word after reset
  localparam logic [31:0] MemResetValue = 32'h0;

endpackage

// File: rtl/axi_pkg.sv
/*
 * AXI4 widths, response codes and the five channel payload structs
 */
package axi_pkg;

  // Bus geometry
  localparam int unsigned IdWidth   = 4;
  localparam int unsigned AddrWidth = 32;
  localparam int unsigned DataWidth = 32;
  localparam int unsigned StrbWidth = DataWidth / 8;

  typedef logic [IdWidth-1:0]   id_t;
  typedef logic [AddrWidth-1:0] addr_t;
  typedef logic [DataWidth-1:0] data_t;
  typedef logic [StrbWidth-1:0] strb_t;
  typedef logic [1:0]           resp_t;

  // Response codes, EXOKAY and DECERR not produced here
  localparam resp_t RespOkay   = 2'b00;
  localparam resp_t RespSlvErr = 2'b10;

  // Write address channel
  typedef struct packed {
    id_t        id;
    addr_t      addr;
    logic [7:0] len;
    logic [2:0] size;
    logic [1:0] burst;
  } aw_chan_t;

  // Write data channel
  typedef struct packed {
    data_t data;
    strb_t strb;
    logic  last;
  } w_chan_t;

  // Write response channel
  typedef struct packed {
    id_t   id;
    resp_t resp;
  } b_chan_t;

  // Read address channel, same layout as aw
  typedef struct packed {
    id_t        id;
    addr_t      addr;
    logic [7:0] len;
    logic [2:0] size;
    logic [1:0] burst;
  } ar_chan_t;

  // Read data channel
  typedef struct packed {
    id_t   id;
    data_t data;
    resp_t resp;
    logic  last;
  } r_chan_t;

endpackage
